/* design/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
	input mips16_pkg::decoded_t dec,
	input mips16_pkg::word_t rx_value,
	output mips16_pkg::wb_t wb
);
	import mips16_pkg::*;

	reg_sel_t rx_sel;
	word_t sum;
	logic cmp_eq;

	assign rx_sel = {1'b0, dec.rx};
	assign sum = rx_value + dec.imm8;
	assign cmp_eq = (rx_value == dec.imm8_zx);

	always_comb begin
		wb.en = 1'b0;
		wb.sel = rx_sel;
		wb.value = '0;

		case (dec.op)
			OP_LI: begin
				wb.en = 1'b1;
				wb.value = dec.imm8_zx;
			end
			OP_ADDIU: begin
				wb.en = 1'b1;
				wb.value = sum;
			end
			OP_CMPI: begin
				wb.en = 1'b1;
				wb.sel = SEL_T;
				wb.value = cmp_eq ? 16'd0 : 16'd1; // T is 0 on match
			end
			default: begin
				wb.en = 1'b0;
			end
		endcase
	end

endmodule

/* design/flow_core.sv */
`timescale 1ns/1ns

module flow_core #(
	parameter int IMEM_DEPTH_LOG2 = 8
) (
	input logic clk,
	input logic reset,
	input logic run,
	input logic load_en,
	input logic [IMEM_DEPTH_LOG2-1:0] load_addr,
	input mips16_pkg::word_t load_data,
	output logic retire_valid,
	output mips16_pkg::retire_t retire
);
	import mips16_pkg::*;

	word_t pc;
	word_t pc_next;
	word_t instr;
	word_t rx_value;
	word_t t_value;
	word_t ra_value;
	decoded_t dec;
	redirect_t redirect;
	wb_t exec_wb;
	wb_t ra_wb;
	wb_t wb_merged;
	wb_t rf_wb;

	instr_mem #(
		.IMEM_DEPTH_LOG2(IMEM_DEPTH_LOG2)
	) u_imem (
		.clk(clk),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.fetch_addr(pc),
		.instr(instr)
	);

	instr_decode u_dec (
		.instr(instr),
		.dec(dec)
	);

	reg_file u_rf (
		.clk(clk),
		.reset(reset),
		.rx(dec.rx),
		.rx_value(rx_value),
		.t_value(t_value),
		.ra_value(ra_value),
		.wb(rf_wb)
	);

	exec_unit u_exec (
		.dec(dec),
		.rx_value(rx_value),
		.wb(exec_wb)
	);

	jmp_ctrl u_jmp (
		.dec(dec),
		.pc(pc),
		.rx_value(rx_value),
		.t_value(t_value),
		.ra_value(ra_value),
		.redirect(redirect),
		.ra_wb(ra_wb)
	);

	// At most one source is enabled per opcode
	assign wb_merged = exec_wb.en ? exec_wb : ra_wb;

	always_comb begin
		rf_wb = wb_merged;
		rf_wb.en = wb_merged.en & run;
	end

	assign pc_next = redirect.set_pc ? redirect.target : pc + 16'd1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (run) begin
			pc <= pc_next;
		end
	end

	// Trace of cycle n shows up in cycle n+1
	always_ff @(posedge clk) begin
		if (reset) begin
			retire_valid <= 1'b0;
			retire <= '0;
		end else begin
			retire_valid <= run;
			if (run) begin
				retire.pc <= pc;
				retire.instr <= instr;
				retire.wb <= wb_merged;
			end
		end
	end

endmodule

/* design/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode (
	input mips16_pkg::word_t instr,
	output mips16_pkg::decoded_t dec
);
	import mips16_pkg::*;

	localparam logic [2:0] SUB_BTEQZ = 3'b000;
	localparam logic [2:0] SUB_BTNEZ = 3'b001;
	localparam logic [7:0] FN_JR = 8'b0000_0000;
	localparam logic [7:0] FN_JALR = 8'b1100_0000;
	localparam logic [7:0] FN_JRRA = 8'b0010_0000;

	major_e major;

	assign major = major_e'(instr[15:11]);

	always_comb begin
		dec.op = OP_NOP; // Unknown encodings retire as NOP
		dec.rx = instr[10:8];
		dec.imm8 = {{8{instr[7]}}, instr[7:0]};
		dec.imm8_zx = {8'h00, instr[7:0]};
		dec.off11 = {{5{instr[10]}}, instr[10:0]};

		case (major)
			MAJ_NOP: begin
				dec.op = OP_NOP;
			end
			MAJ_LI: begin
				dec.op = OP_LI;
			end
			MAJ_ADDIU: begin
				dec.op = OP_ADDIU;
			end
			MAJ_CMPI: begin
				dec.op = OP_CMPI;
			end
			MAJ_B: begin
				dec.op = OP_B;
			end
			MAJ_BEQZ: begin
				dec.op = OP_BEQZ;
			end
			MAJ_BNEZ: begin
				dec.op = OP_BNEZ;
			end
			MAJ_TBR: begin
				if (instr[10:8] == SUB_BTEQZ) begin
					dec.op = OP_BTEQZ;
				end else if (instr[10:8] == SUB_BTNEZ) begin
					dec.op = OP_BTNEZ;
				end
			end
			MAJ_JMP: begin
				if (instr[7:0] == FN_JR) begin
					dec.op = OP_JR;
				end else if (instr[7:0] == FN_JALR) begin
					dec.op = OP_JALR;
				end else if (instr[7:0] == FN_JRRA && instr[10:8] == 3'b000) begin
					dec.op = OP_JRRA;
				end
			end
			default: begin
				dec.op = OP_NOP;
			end
		endcase
	end

endmodule

/* design/instr_mem.sv */
`timescale 1ns/1ns

module instr_mem #(
	parameter int IMEM_DEPTH_LOG2 = 8
) (
	input logic clk,
	input logic load_en,
	input logic [IMEM_DEPTH_LOG2-1:0] load_addr,
	input mips16_pkg::word_t load_data,
	input mips16_pkg::word_t fetch_addr,
	output mips16_pkg::word_t instr
);
	import mips16_pkg::*;

	localparam int DEPTH = 1 << IMEM_DEPTH_LOG2;

	word_t mem [DEPTH];
	logic [IMEM_DEPTH_LOG2-1:0] fetch_idx;

	// Loaded from outside while the core is stopped
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	// PC wraps modulo the depth
	always_comb begin
		fetch_idx = '0;
		for (int i = 0; i < IMEM_DEPTH_LOG2; i++) begin
			if (i < $bits(word_t)) begin
				fetch_idx[i] = fetch_addr[i];
			end
		end
	end

	assign instr = mem[fetch_idx]; // Asynchronous read

endmodule

/* design/jmp_ctrl.sv */
`timescale 1ns/1ns

module jmp_ctrl (
	input mips16_pkg::decoded_t dec,
	input mips16_pkg::word_t pc,
	input mips16_pkg::word_t rx_value,
	input mips16_pkg::word_t t_value,
	input mips16_pkg::word_t ra_value,
	output mips16_pkg::redirect_t redirect,
	output mips16_pkg::wb_t ra_wb
);
	import mips16_pkg::*;

	word_t pc_inc;
	word_t br_target; // Conditional branches, 8-bit offset
	word_t b_target;
	logic rx_zero;
	logic t_zero;

	assign pc_inc = pc + 16'd1;
	assign br_target = pc_inc + dec.imm8;
	assign b_target = pc_inc + dec.off11;
	assign rx_zero = (rx_value == '0);
	assign t_zero = (t_value == '0);

	always_comb begin
		redirect.set_pc = 1'b0;
		redirect.target = br_target;
		ra_wb.en = 1'b0;
		ra_wb.sel = SEL_RA;
		ra_wb.value = pc_inc;

		case (dec.op)
			OP_B: begin
				redirect.set_pc = 1'b1;
				redirect.target = b_target;
			end
			OP_BEQZ: begin
				redirect.set_pc = rx_zero;
			end
			OP_BNEZ: begin
				redirect.set_pc = !rx_zero;
			end
			OP_BTEQZ: begin
				redirect.set_pc = t_zero;
			end
			OP_BTNEZ: begin
				redirect.set_pc = !t_zero;
			end
			OP_JR: begin
				redirect.set_pc = 1'b1;
				redirect.target = rx_value; // Exact, no +1
			end
			OP_JALR: begin
				redirect.set_pc = 1'b1;
				redirect.target = rx_value;
				ra_wb.en = 1'b1; // Link PC+1
			end
			OP_JRRA: begin
				redirect.set_pc = 1'b1;
				redirect.target = ra_value;
			end
			default: begin
				redirect.set_pc = 1'b0;
			end
		endcase
	end

endmodule

/* design/mips16_pkg.sv */
package mips16_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_sel_t;

	localparam reg_sel_t SEL_T = 4'd8;
	localparam reg_sel_t SEL_RA = 4'd9;

	// Major opcode field, instr[15:11]
	typedef enum logic [4:0] {
		MAJ_NOP = 5'b00001,
		MAJ_B = 5'b00010,
		MAJ_BEQZ = 5'b00100,
		MAJ_BNEZ = 5'b00101,
		MAJ_ADDIU = 5'b01001,
		MAJ_TBR = 5'b01100, // BTEQZ / BTNEZ
		MAJ_LI = 5'b01101,
		MAJ_CMPI = 5'b01110,
		MAJ_JMP = 5'b11101 // JR / JALR / JRRA
	} major_e;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_LI,
		OP_ADDIU,
		OP_CMPI,
		OP_B,
		OP_BEQZ,
		OP_BNEZ,
		OP_BTEQZ,
		OP_BTNEZ,
		OP_JR,
		OP_JALR,
		OP_JRRA
	} op_e;

	typedef struct packed {
		op_e op;
		logic [2:0] rx;
		word_t imm8; // Sign extended
		word_t imm8_zx;
		word_t off11; // Sign extended
	} decoded_t;

	typedef struct packed {
		logic set_pc;
		word_t target;
	} redirect_t;

	typedef struct packed {
		logic en;
		reg_sel_t sel;
		word_t value;
	} wb_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
		wb_t wb;
	} retire_t;

endpackage

/* design/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
	input logic clk,
	input logic reset,
	input logic [2:0] rx,
	output mips16_pkg::word_t rx_value,
	output mips16_pkg::word_t t_value,
	output mips16_pkg::word_t ra_value,
	input mips16_pkg::wb_t wb
);
	import mips16_pkg::*;

	word_t gpr [8];
	word_t t_reg;
	word_t ra_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++) begin
				gpr[i] <= '0;
			end
			t_reg <= '0;
			ra_reg <= '0;
		end else if (wb.en) begin
			case (wb.sel)
				SEL_T: begin
					t_reg <= wb.value;
				end
				SEL_RA: begin
					ra_reg <= wb.value;
				end
				default: begin
					if (wb.sel < SEL_T) begin // General registers only
						gpr[wb.sel[2:0]] <= wb.value;
					end
				end
			endcase
		end
	end

	// No bypass, reads see the value before this edge
	assign rx_value = gpr[rx];
	assign t_value = t_reg;
	assign ra_value = ra_reg;

endmodule

/* mips16_flow.f */
design/mips16_pkg.sv
design/instr_mem.sv
design/reg_file.sv
design/instr_decode.sv
design/exec_unit.sv
design/jmp_ctrl.sv
design/flow_core.sv
testbench/flow_core_assert.sv
testbench/tb_flow_core.sv

/* testbench/flow_core_assert.sv */
`timescale 1ns/1ns

module flow_core_assert (
	input logic clk,
	input logic reset,
	input logic run,
	input logic retire_valid,
	input mips16_pkg::word_t pc,
	input mips16_pkg::retire_t retire
);
	import mips16_pkg::*;

	a_reset_quiet: assert property (@(posedge clk) reset |=> !retire_valid)
		else $error("retire_valid high in the cycle after reset");

	a_stop_quiet: assert property (@(posedge clk) disable iff (reset)
		!run |=> !retire_valid)
		else $error("retire_valid high one cycle after run was low");

	a_pc_hold: assert property (@(posedge clk) disable iff (reset)
		!run |=> $stable(pc))
		else $error("PC moved while run was low");

	a_wb_sel: assert property (@(posedge clk) disable iff (reset)
		retire.wb.en |-> retire.wb.sel <= SEL_RA)
		else $error("retire write enable with select above 9");

endmodule

bind flow_core flow_core_assert u_assert (
	.clk(clk),
	.reset(reset),
	.run(run),
	.retire_valid(retire_valid),
	.pc(pc),
	.retire(retire)
);

/* testbench/tb_flow_core.sv */
`timescale 1ns/1ns

module tb_flow_core;
	import mips16_pkg::*;

	// Major opcodes, index 0 at the low end
	localparam logic [44:0] MAJ_TBL = {5'b11101, 5'b01100, 5'b00101, 5'b00100, 5'b00010,
		5'b01110, 5'b01001, 5'b01101, 5'b00001};

	logic clk;
	logic reset;
	logic run;
	logic load_en;
	logic [7:0] load_addr;
	word_t load_data;
	logic retire_valid;
	retire_t retire;

	word_t mem_img [256]; // Image of the instruction memory
	word_t ref_pc;
	word_t ref_gpr [8];
	word_t ref_t;
	word_t ref_ra;
	logic [31:0] rng = 32'd79082;
	int err_count = 0;
	int check_count = 0;
	int retire_total = 0;
	int err_mark = 0;

	flow_core #(
		.IMEM_DEPTH_LOG2(8)
	) dut0 (
		.clk(clk), .reset(reset), .run(run), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .retire_valid(retire_valid), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Mode 0 data only, 1 conditions and branches, 2 everything plus raw words
	function automatic word_t rand_instr(int mode);
		logic [31:0] r;
		int k;
		word_t ins;
		r = next_rand();
		if (mode == 0) begin
			k = r[17:16];
		end else if (mode == 1) begin
			k = r[18:16] % 7 + 1;
		end else begin
			k = r[19:16] % 10;
		end
		if (k == 9) begin
			r = next_rand();
			return r[26:11]; // Mostly unknown encodings
		end
		ins = {MAJ_TBL[k * 5 +: 5], r[10:0]};
		if (mode == 1 && k != 4) begin
			ins[10] = 1'b0; // Fewer registers, more zero hits
		end
		if (mode == 1 && (k == 1 || k == 3)) begin
			ins[7:2] = '0;
		end
		if (k == 7) begin
			ins[10:9] = 2'b00; // BTEQZ or BTNEZ
		end
		if (k == 8) begin
			ins[7:0] = (r[13:12] == 2'd0) ? 8'h00 : (r[13:12] == 2'd1) ? 8'hC0 : 8'h20;
			if (ins[7:0] == 8'h20) begin
				ins[10:8] = 3'd0;
			end
		end
		return ins;
	endfunction

	function automatic void fill_mem(int mode);
		for (int a = 0; a < 256; a++) begin
			if (mode < 0) begin
				mem_img[a] = {8'h08, a[7:0]}; // NOP, low bits carry the address
			end else begin
				mem_img[a] = rand_instr(mode);
			end
		end
	endfunction

	// Instruction-set model, one retirement per call
	function automatic retire_t step_ref();
		retire_t r;
		word_t ins;
		word_t rxv;
		word_t imm;
		word_t nxt;
		ins = mem_img[ref_pc[7:0]];
		rxv = ref_gpr[ins[10:8]];
		imm = {{8{ins[7]}}, ins[7:0]};
		nxt = ref_pc + 16'd1;
		r = '0;
		r.pc = ref_pc;
		r.instr = ins;
		case (ins[15:11])
			5'b01101: r.wb = {1'b1, 1'b0, ins[10:8], 8'h00, ins[7:0]}; // LI
			5'b01001: r.wb = {1'b1, 1'b0, ins[10:8], rxv + imm}; // ADDIU
			5'b01110: r.wb = {1'b1, 4'd8, 15'd0, rxv != {8'h00, ins[7:0]}}; // CMPI
			5'b00010: nxt = nxt + {{5{ins[10]}}, ins[10:0]};
			5'b00100: nxt = (rxv == 16'd0) ? nxt + imm : nxt;
			5'b00101: nxt = (rxv != 16'd0) ? nxt + imm : nxt;
			5'b01100: nxt = (ins[10:9] == 2'b00 && ins[8] == (ref_t != 16'd0)) ? nxt + imm : nxt;
			5'b11101: begin
				if (ins[7:0] == 8'h00 || ins[7:0] == 8'hC0) begin
					nxt = rxv; // JR, JALR
				end else if (ins[7:0] == 8'h20 && ins[10:8] == 3'd0) begin
					nxt = ref_ra;
				end
				if (ins[7:0] == 8'hC0) begin
					r.wb = {1'b1, 4'd9, ref_pc + 16'd1};
				end
			end
			default: begin
			end
		endcase
		if (r.wb.en && r.wb.sel == 4'd8) begin
			ref_t = r.wb.value;
		end else if (r.wb.en && r.wb.sel == 4'd9) begin
			ref_ra = r.wb.value;
		end else if (r.wb.en) begin
			ref_gpr[r.wb.sel[2:0]] = r.wb.value;
		end
		ref_pc = nxt;
		return r;
	endfunction

	task automatic check_word(string name, word_t exp, word_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("CHECK FAILED %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	always @(posedge clk) begin : compare
		retire_t exp;
		if (retire_valid === 1'b1) begin
			exp = step_ref();
			retire_total++;
			check_word("retire.pc", exp.pc, retire.pc);
			check_word("retire.instr", exp.instr, retire.instr);
			check_word("retire.wb.en", exp.wb.en, retire.wb.en);
			if (exp.wb.en) begin
				check_word("retire.wb.sel", exp.wb.sel, retire.wb.sel);
				check_word("retire.wb.value", exp.wb.value, retire.wb.value);
			end
		end
	end

	task automatic load_and_reset();
		for (int a = 0; a < 256; a++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= a[7:0];
			load_data <= mem_img[a];
		end
		@(posedge clk);
		load_en <= 1'b0;
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		ref_pc = '0;
		ref_t = '0;
		ref_ra = '0;
		for (int i = 0; i < 8; i++) begin
			ref_gpr[i] = '0;
		end
	endtask

	// Run for n cycles, then expect exactly n retirements and a quiet trace
	task automatic run_and_wait(int n);
		int target;
		int waited;
		target = retire_total + n;
		if (n > 0) begin
			@(posedge clk);
			run <= 1'b1;
			repeat (n) @(posedge clk);
			run <= 1'b0;
		end
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (retire_valid !== 1'b0 && waited < 16);
		if (retire_valid !== 1'b0) begin
			$display("Timeout: trace still running 16 cycles after run went low");
			err_count++;
		end
		repeat (3) @(posedge clk);
		if (retire_total != target) begin
			$display("Trace gave %0d retirements where %0d were expected", retire_total, target);
			err_count++;
		end
	endtask

	task automatic report(int num, string name);
		$display("test %0d %s done: %0d retired in total, %0d errors", num, name,
			retire_total, err_count - err_mark);
		err_mark = err_count;
	endtask

	initial begin
		reset = 1'b1;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;

		fill_mem(-1);
		load_and_reset();
		run_and_wait(0); // Run low after reset
		run_and_wait(40);
		report(1, "nop sweep");

		fill_mem(0);
		mem_img[0] = 16'h6905; // LI r1, 5
		mem_img[1] = 16'h7105; // CMPI r1, 5
		mem_img[2] = 16'h7106;
		mem_img[3] = 16'h49FD; // ADDIU r1, -3
		mem_img[4] = 16'h4A80;
		mem_img[5] = 16'h6AFF;
		load_and_reset();
		run_and_wait(64);
		report(2, "data ops");

		fill_mem(1);
		load_and_reset();
		run_and_wait(400);
		report(3, "branches");

		fill_mem(-1);
		mem_img[0] = 16'h6B20; // LI r3, 0x20
		mem_img[1] = 16'hEBC0; // JALR r3
		mem_img[32] = 16'h4C07;
		mem_img[33] = 16'hE820; // JRRA
		mem_img[2] = 16'h6D40;
		mem_img[3] = 16'hED00; // JR r5
		load_and_reset();
		run_and_wait(8);
		report(4, "jumps and link");

		fill_mem(2);
		load_and_reset();
		run_and_wait(2000);
		report(5, "random programs");

		fill_mem(2);
		load_and_reset();
		run_and_wait(150);
		run_and_wait(150); // Resumes at the held PC
		report(6, "stop and resume");

		$display("6 tests, %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
